//--- gnn_pkg.sv
package gnn_pkg;

    // graph shape
    localparam int num_nodes = 4;
    // features per node, also hidden neurons per node
    localparam int num_feat  = 4;
    localparam int num_out   = 2;

    // datapath widths, grown just enough at each stage
    localparam int feat_w    = 5;
    localparam int weight_w  = 5;
    // sum of three features
    localparam int agg_w     = 7;
    // four 7x5 products summed
    localparam int hidden_w  = 14;
    // sum of three relu outputs
    localparam int hagg_w    = 16;
    localparam int out_w     = 21;

    // agg + mac + relu + agg + output
    localparam int pipe_latency = 5;

    typedef logic signed [feat_w-1:0]   feat_t;
    typedef logic signed [weight_w-1:0] weight_t;
    typedef logic signed [agg_w-1:0]    agg_t;
    typedef logic signed [hidden_w-1:0] hidden_t;
    typedef logic signed [hagg_w-1:0]   hagg_t;
    typedef logic signed [out_w-1:0]    out_t;

    // one node, x0 in the low bits
    typedef struct packed {
        feat_t x3;
        feat_t x2;
        feat_t x1;
        feat_t x0;
    } node_feat_t;

    // whole graph, node0 in the low bits
    typedef struct packed {
        node_feat_t node3;
        node_feat_t node2;
        node_feat_t node1;
        node_feat_t node0;
    } graph_feat_t;

    // wkj is input k to neuron j
    // field order lines up with a [k][j] array view
    typedef struct packed {
        weight_t w33;
        weight_t w32;
        weight_t w31;
        weight_t w30;
        weight_t w23;
        weight_t w22;
        weight_t w21;
        weight_t w20;
        weight_t w13;
        weight_t w12;
        weight_t w11;
        weight_t w10;
        weight_t w03;
        weight_t w02;
        weight_t w01;
        weight_t w00;
    } hidden_weights_t;

    // wjm is neuron j to output m, same [j][m] layout
    typedef struct packed {
        weight_t w31;
        weight_t w30;
        weight_t w21;
        weight_t w20;
        weight_t w11;
        weight_t w10;
        weight_t w01;
        weight_t w00;
    } output_weights_t;

    typedef struct packed {
        out_t y1;
        out_t y0;
    } node_out_t;

    typedef struct packed {
        node_out_t node3;
        node_out_t node2;
        node_out_t node1;
        node_out_t node0;
    } graph_out_t;

endpackage

//--- neighbor_aggregate.sv
module neighbor_aggregate
    import gnn_pkg::*;
#(
    // element width coming in
    parameter int in_w  = feat_w,
    // must be at least in_w + 2 so three terms never wrap
    parameter int out_w = agg_w
) (
    input  logic clk,
    input  logic rst_n,
    input  logic in_valid,
    input  logic signed [num_nodes-1:0][num_feat-1:0][in_w-1:0]  in_vec,
    output logic out_valid,
    output logic signed [num_nodes-1:0][num_feat-1:0][out_w-1:0] out_vec
);

    // combinational sums ahead of the register
    logic signed [num_nodes-1:0][num_feat-1:0][out_w-1:0] sum_next;

    // graph adjacency lives here only
    // node i sees every node except node 3-i
    //   node0 -> 0,1,2
    //   node1 -> 0,1,3
    //   node2 -> 0,2,3
    //   node3 -> 1,2,3
    always_comb begin
        sum_next = '0;
        for (int i = 0; i < num_nodes; i++) begin
            for (int f = 0; f < num_feat; f++) begin
                for (int n = 0; n < num_nodes; n++) begin
                    // skip the one non-neighbour
                    if (n != num_nodes - 1 - i) begin
                        // packed selects are unsigned, so re-sign both sides
                        sum_next[i][f] = $signed(sum_next[i][f]) + $signed(in_vec[n][f]);
                    end
                end
            end
        end
    end

    // data loads only with a valid graph
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_vec <= '0;
        end else if (in_valid) begin
            out_vec <= sum_next;
        end
    end

    // valid follows input by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

endmodule

//--- hidden_layer.sv
module hidden_layer
    import gnn_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 in_valid,
    input  agg_t    [num_nodes-1:0][num_feat-1:0] in_vec,
    input  hidden_weights_t                      weights,
    output logic                                 out_valid,
    output hidden_t [num_nodes-1:0][num_feat-1:0] out_vec
);

    // weights viewed as w[k][j], input k to neuron j
    weight_t [num_feat-1:0][num_feat-1:0] w;

    // mac stage
    hidden_t [num_nodes-1:0][num_feat-1:0] mac_next;
    hidden_t [num_nodes-1:0][num_feat-1:0] mac_q;
    logic                                  mac_valid;

    // struct fields are laid out to match the array view bit for bit
    assign w = weights;

    // same 4x4 weight matrix shared by all nodes
    always_comb begin
        mac_next = '0;
        for (int n = 0; n < num_nodes; n++) begin
            for (int j = 0; j < num_feat; j++) begin
                for (int k = 0; k < num_feat; k++) begin
                    // signed multiply, extended to hidden_w first
                    mac_next[n][j] = mac_next[n][j] + in_vec[n][k] * w[k][j];
                end
            end
        end
    end

    // stage 1, weighted sums
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mac_q <= '0;
        end else if (in_valid) begin
            mac_q <= mac_next;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mac_valid <= 1'b0;
        end else begin
            mac_valid <= in_valid;
        end
    end

    // stage 2, relu clamp
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_vec <= '0;
        end else if (mac_valid) begin
            for (int n = 0; n < num_nodes; n++) begin
                for (int j = 0; j < num_feat; j++) begin
                    // negative -> zero, sign bit decides
                    if (mac_q[n][j][hidden_w-1]) begin
                        out_vec[n][j] <= '0;
                    end else begin
                        out_vec[n][j] <= mac_q[n][j];
                    end
                end
            end
        end
    end

    // valid lands with the relu data
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= mac_valid;
        end
    end

endmodule

//--- output_layer.sv
module output_layer
    import gnn_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 in_valid,
    input  hagg_t [num_nodes-1:0][num_feat-1:0]  in_vec,
    input  output_weights_t                      weights,
    output logic                                 out_valid,
    output graph_out_t                           result
);

    // weights viewed as w[j][m], neuron j to output m
    weight_t [num_feat-1:0][num_out-1:0] w;

    // per node outputs before the register, same layout as graph_out_t
    out_t [num_nodes-1:0][num_out-1:0] res_next;

    assign w = weights;

    // shared 4x2 matrix, accumulated at full output width
    always_comb begin
        res_next = '0;
        for (int n = 0; n < num_nodes; n++) begin
            for (int m = 0; m < num_out; m++) begin
                for (int j = 0; j < num_feat; j++) begin
                    // operands sign-extended to out_w before the multiply
                    res_next[n][m] = res_next[n][m] + in_vec[n][j] * w[j][m];
                end
            end
        end
    end

    // final result register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
        end else if (in_valid) begin
            // node0 y0 sits in the low bits on both sides
            result <= res_next;
        end
    end

    // single strobe for all eight outputs
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

endmodule

//--- gnn_top.sv
module gnn_top
    import gnn_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    // one graph per strobe, no back-pressure
    input  logic            in_valid,
    input  graph_feat_t     feat,
    // must hold steady while a graph is in flight
    input  hidden_weights_t hidden_weights,
    input  output_weights_t output_weights,
    // pulses pipe_latency cycles after in_valid
    output logic            out_valid,
    output graph_out_t      result
);

    // first aggregation, t+1
    agg_t    [num_nodes-1:0][num_feat-1:0] agg_vec;
    logic                                  agg_valid;

    // hidden layer after relu, t+3
    hidden_t [num_nodes-1:0][num_feat-1:0] relu_vec;
    logic                                  relu_valid;

    // second aggregation, t+4
    hagg_t   [num_nodes-1:0][num_feat-1:0] hagg_vec;
    logic                                  hagg_valid;

    // raw features summed over neighbours
    // graph struct bits feed the node-by-feature array directly
    neighbor_aggregate #(
        .in_w  (feat_w),
        .out_w (agg_w)
    ) agg_in (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_vec    (feat),
        .out_valid (agg_valid),
        .out_vec   (agg_vec)
    );

    // 4x4 mac then relu, two cycles
    hidden_layer hidden (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (agg_valid),
        .in_vec    (agg_vec),
        .weights   (hidden_weights),
        .out_valid (relu_valid),
        .out_vec   (relu_vec)
    );

    // same adjacency, wider elements
    neighbor_aggregate #(
        .in_w  (hidden_w),
        .out_w (hagg_w)
    ) agg_hidden (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (relu_valid),
        .in_vec    (relu_vec),
        .out_valid (hagg_valid),
        .out_vec   (hagg_vec)
    );

    // 4x2 output, t+5
    output_layer out_layer (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (hagg_valid),
        .in_vec    (hagg_vec),
        .weights   (output_weights),
        .out_valid (out_valid),
        .result    (result)
    );

endmodule

//--- gnn_checker.sv
module gnn_checker
    import gnn_pkg::*;
(
    input logic                                  clk,
    input logic                                  rst_n,
    input logic                                  in_valid,
    input graph_feat_t                           feat,
    input hidden_weights_t                       hidden_weights,
    input output_weights_t                       output_weights,
    input logic                                  out_valid,
    input graph_out_t                            result,
    input logic                                  relu_valid,
    input hidden_t [num_nodes-1:0][num_feat-1:0] relu_vec
);
    timeunit 1ns;
    timeprecision 100ps;

    // expected result for whatever sits on the inputs this cycle
    graph_out_t model_now;
    // full-precision outputs of this cycle's graph all fit in out_w
    bit         model_fits;
    // one slot per pipeline cycle, oldest at the top index
    graph_out_t model_q [pipe_latency];

    // reference model from the layer rules, plain ints throughout
    function automatic graph_out_t model_result(
        input  graph_feat_t     g,
        input  hidden_weights_t hw,
        input  output_weights_t ow,
        output bit              fits
    );
        int x  [num_nodes][num_feat];
        int a  [num_nodes][num_feat];
        int h  [num_nodes][num_feat];
        int b  [num_nodes][num_feat];
        int wh [num_feat][num_feat];
        int wo [num_feat][num_out];
        int y;
        graph_out_t r;
        // node n feature f sits at slot n*num_feat+f
        for (int n = 0; n < num_nodes; n++) begin
            for (int f = 0; f < num_feat; f++) begin
                x[n][f] = int'(feat_t'(g[(n*num_feat+f)*feat_w +: feat_w]));
            end
        end
        // input k to neuron j
        for (int k = 0; k < num_feat; k++) begin
            for (int j = 0; j < num_feat; j++) begin
                wh[k][j] = int'(weight_t'(hw[(k*num_feat+j)*weight_w +: weight_w]));
            end
            for (int m = 0; m < num_out; m++) begin
                wo[k][m] = int'(weight_t'(ow[(k*num_out+m)*weight_w +: weight_w]));
            end
        end
        // first aggregation, node i leaves out node 3-i
        for (int i = 0; i < num_nodes; i++) begin
            for (int f = 0; f < num_feat; f++) begin
                a[i][f] = 0;
                for (int n = 0; n < num_nodes; n++) begin
                    if (n != num_nodes - 1 - i) begin
                        a[i][f] += x[n][f];
                    end
                end
            end
        end
        // hidden layer then relu
        for (int n = 0; n < num_nodes; n++) begin
            for (int j = 0; j < num_feat; j++) begin
                h[n][j] = 0;
                for (int k = 0; k < num_feat; k++) begin
                    h[n][j] += a[n][k] * wh[k][j];
                end
                if (h[n][j] < 0) begin
                    h[n][j] = 0;
                end
            end
        end
        // second aggregation, same neighbours
        for (int i = 0; i < num_nodes; i++) begin
            for (int f = 0; f < num_feat; f++) begin
                b[i][f] = 0;
                for (int n = 0; n < num_nodes; n++) begin
                    if (n != num_nodes - 1 - i) begin
                        b[i][f] += h[n][f];
                    end
                end
            end
        end
        // output layer, node n output m at slot n*num_out+m
        r    = '0;
        fits = 1'b1;
        for (int n = 0; n < num_nodes; n++) begin
            for (int m = 0; m < num_out; m++) begin
                y = 0;
                for (int j = 0; j < num_feat; j++) begin
                    y += b[n][j] * wo[j][m];
                end
                // signed range of out_w
                if (y >= (1 << (out_w - 1)) || y < -(1 << (out_w - 1))) begin
                    fits = 1'b0;
                end
                r[(n*num_out+m)*out_w +: out_w] = out_t'(y);
            end
        end
        return r;
    endfunction

    // true when no hidden value came out negative
    function automatic bit all_non_negative(input hidden_t [num_nodes-1:0][num_feat-1:0] v);
        bit ok;
        ok = 1'b1;
        for (int n = 0; n < num_nodes; n++) begin
            for (int j = 0; j < num_feat; j++) begin
                if ($signed(v[n][j]) < 0) begin
                    ok = 1'b0;
                end
            end
        end
        return ok;
    endfunction

    always_comb begin
        model_now = model_result(feat, hidden_weights, output_weights, model_fits);
    end

    // expected values ride along with the graph
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < pipe_latency; i++) begin
                model_q[i] <= '0;
            end
        end else begin
            model_q[0] <= model_now;
            for (int i = 1; i < pipe_latency; i++) begin
                model_q[i] <= model_q[i-1];
            end
        end
    end

    // pipe stays quiet under reset
    reset_quiet: assert property (@(posedge clk) !rst_n |-> !out_valid)
        else begin
            tb_gnn.error_count++;
            $error("out_valid was high while reset was held");
        end

    valid_follows: assert property (@(posedge clk) disable iff (!rst_n)
        $past(in_valid, pipe_latency) |-> out_valid)
        else begin
            tb_gnn.error_count++;
            $error("no out_valid %0d cycles after in_valid", pipe_latency);
        end

    // no result without a graph behind it
    valid_caused: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> $past(in_valid, pipe_latency))
        else begin
            tb_gnn.error_count++;
            $error("out_valid rose with no matching in_valid");
        end

    result_match: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> result == model_q[pipe_latency-1])
        else begin
            tb_gnn.error_count++;
            $error("ERROR %s: expected %h actual %h", tb_gnn.test_name,
                   $sampled(model_q[pipe_latency-1]), $sampled(result));
        end

    // output width holds the exact result of every accepted graph
    no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> model_fits)
        else begin
            tb_gnn.error_count++;
            $error("in test %s an exact output does not fit in %0d bits",
                   tb_gnn.test_name, out_w);
        end

    // clamp visible at the relu register
    relu_clamped: assert property (@(posedge clk) disable iff (!rst_n)
        relu_valid |-> all_non_negative(relu_vec))
        else begin
            tb_gnn.error_count++;
            $error("negative value left the relu stage");
        end

endmodule

//--- tb_gnn.sv
module tb_gnn
    import gnn_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    logic            clk;
    logic            rst_n;
    logic            in_valid;
    graph_feat_t     feat;
    hidden_weights_t hidden_weights;
    output_weights_t output_weights;
    logic            out_valid;
    graph_out_t      result;

    // bumped by the checker action blocks and by timeouts
    int    error_count;
    string test_name;
    int    test_count;
    // graphs in and results out, counted at the clock edge
    int    sent_count;
    int    seen_count;

    gnn_top uut (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .feat           (feat),
        .hidden_weights (hidden_weights),
        .output_weights (output_weights),
        .out_valid      (out_valid),
        .result         (result)
    );

    bind gnn_top gnn_checker checks (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .feat           (feat),
        .hidden_weights (hidden_weights),
        .output_weights (output_weights),
        .out_valid      (out_valid),
        .result         (result),
        .relu_valid     (relu_valid),
        .relu_vec       (relu_vec)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        if (rst_n && in_valid) begin
            sent_count++;
        end
        if (rst_n && out_valid) begin
            seen_count++;
        end
    end

    // inputs move 1 ns after the edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // one graph for one cycle, in_valid left high for streaming
    task automatic present(input graph_feat_t g, input hidden_weights_t hw,
                           input output_weights_t ow);
        in_valid       = 1'b1;
        feat           = g;
        hidden_weights = hw;
        output_weights = ow;
        step();
    endtask

    // weights stay put until every result is out
    task automatic wait_drained();
        int cycles;
        in_valid = 1'b0;
        cycles   = 0;
        while (seen_count != sent_count && cycles < pipe_latency * 4) begin
            step();
            cycles++;
        end
        if (seen_count != sent_count) begin
            $display("timeout in %s: %0d graphs sent but %0d results seen",
                     test_name, sent_count, seen_count);
            error_count++;
        end
    endtask

    task automatic end_test(input int errors_at_start);
        test_count++;
        if (error_count == errors_at_start) begin
            $display("test %-10s ok", test_name);
        end else begin
            $display("test %-10s %0d errors", test_name, error_count - errors_at_start);
        end
    endtask

    function automatic graph_feat_t random_feat();
        logic [95:0] bits;
        bits = {$urandom(), $urandom(), $urandom()};
        return bits[79:0];
    endfunction

    function automatic hidden_weights_t random_hidden();
        logic [95:0] bits;
        bits = {$urandom(), $urandom(), $urandom()};
        return bits[79:0];
    endfunction

    function automatic output_weights_t random_output();
        logic [63:0] bits;
        bits = {$urandom(), $urandom()};
        return bits[39:0];
    endfunction

    // magnitudes 1..15 with the sign bit clear
    function automatic graph_feat_t positive_feat();
        graph_feat_t g;
        for (int i = 0; i < num_nodes * num_feat; i++) begin
            g[i*feat_w +: feat_w] = {1'b0, 4'($urandom_range(15, 1))};
        end
        return g;
    endfunction

    // sign bit set, so -16..-1
    function automatic hidden_weights_t negative_hidden();
        hidden_weights_t hw;
        for (int i = 0; i < num_feat * num_feat; i++) begin
            hw[i*weight_w +: weight_w] = {1'b1, 4'($urandom())};
        end
        return hw;
    endfunction

    function automatic graph_feat_t fill_feat(input bit use_max);
        feat_t f;
        f = use_max ? {1'b0, {(feat_w-1){1'b1}}} : {1'b1, {(feat_w-1){1'b0}}};
        return {(num_nodes*num_feat){f}};
    endfunction

    function automatic weight_t extreme_weight(input bit use_max);
        return use_max ? {1'b0, {(weight_w-1){1'b1}}} : {1'b1, {(weight_w-1){1'b0}}};
    endfunction

    initial begin
        int errors_at_start;
        hidden_weights_t hw;
        output_weights_t ow;
        void'($urandom(84001));
        rst_n          = 1'b0;
        in_valid       = 1'b0;
        feat           = '0;
        hidden_weights = '0;
        output_weights = '0;
        error_count    = 0;
        test_count     = 0;
        sent_count     = 0;
        seen_count     = 0;

        test_name = "reset";
        errors_at_start = error_count;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // idle pipe, out_valid must stay low
        repeat (pipe_latency + 3) step();
        end_test(errors_at_start);

        // lone graphs with gaps between them
        test_name = "latency";
        errors_at_start = error_count;
        for (int i = 0; i < 3; i++) begin
            present(random_feat(), random_hidden(), random_output());
            wait_drained();
            step();
        end
        end_test(errors_at_start);

        test_name = "values";
        errors_at_start = error_count;
        for (int i = 0; i < 10; i++) begin
            present(random_feat(), random_hidden(), random_output());
            wait_drained();
        end
        end_test(errors_at_start);

        // positive sums meet negative weights, clamp gives all zeros
        test_name = "relu";
        errors_at_start = error_count;
        for (int i = 0; i < 4; i++) begin
            present(positive_feat(), negative_hidden(), random_output());
            wait_drained();
        end
        end_test(errors_at_start);

        // one weight set shared by the whole burst
        test_name = "streaming";
        errors_at_start = error_count;
        hw = random_hidden();
        ow = random_output();
        for (int i = 0; i < 20; i++) begin
            present(random_feat(), hw, ow);
        end
        wait_drained();
        end_test(errors_at_start);

        // every min/max mix of features and both weight sets
        test_name = "extremes";
        errors_at_start = error_count;
        for (int c = 0; c < 8; c++) begin
            present(fill_feat(c[0]), {(num_feat*num_feat){extreme_weight(c[1])}},
                    {(num_feat*num_out){extreme_weight(c[2])}});
            wait_drained();
        end
        end_test(errors_at_start);

        step();
        step();
        $display("tests %0d, graphs %0d, results %0d, errors %0d",
                 test_count, sent_count, seen_count, error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- all.f
gnn_pkg.sv
neighbor_aggregate.sv
hidden_layer.sv
output_layer.sv
gnn_top.sv
gnn_checker.sv
tb_gnn.sv

//--- Makefile
# Verilator build and run of the GNN accelerator testbench

SIM = obj_dir/Vtb_gnn

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module tb_gnn -f all.f

# the assertion error limit is raised so every failure gets counted
run: compile
	./$(SIM) +verilator+error+limit+1000 > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	@if grep -q "=== FAIL ===" sim.log; then echo "simulation failed"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir sim.log
